//--- verilog.f
+incdir+rtl
rtl/cordicPkg.sv
rtl/wbCordicPort.sv
rtl/quadrantFold.sv
rtl/cordicStage.sv
rtl/resultQueue.sv
rtl/cordicTop.sv
verif/tbCordic.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tbCordic
FILELIST = verilog.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(BUILD_DIR)

//--- verif/tbCordic.sv
`timescale 1ns/1ps
`include "cordic_cfg.svh"

module tbCordic;
	localparam int ClkPeriod = 40;
	localparam int ResetCycles = 5;
	localparam int Tolerance = 64;
	localparam int HoldCycles = 2 * (`CORDIC_STAGES + 4);
	localparam int CycleLimit = 40 * (`CORDIC_STAGES + 20) + 1000;
	localparam real Pi = 3.14159265358979323846;
	localparam real Scale = 1073741824.0;
	localparam real Turn = 4294967296.0;

	logic              C;
	logic              arstN;
	cordicPkg::wbReq_t wbReq;
	cordicPkg::wbRsp_t wbRsp;
	logic [15:0]       lfsrState = 16'd55;
	int                cycleCount = 0;

	cordicTop i_cordicTop (
		.C     (C),
		.arstN (arstN),
		.wbReq (wbReq),
		.wbRsp (wbRsp)
	);

	initial begin
		C = 1'b0;
		forever begin
			#(ClkPeriod / 2) C = ~C;
		end
	end

	// hang guard
	always @(posedge C) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CycleLimit) begin
			$display("the run hung: tests did not finish within %0d cycles", CycleLimit);
			abortRun();
		end
	end

	////////////////////////////////////////
	// failure handling
	////////////////////////////////////////

	task automatic abortRun();
		$display("STATUS: FAIL");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic reportValue(input string msg);
		$display("FAILED at %0t ns: %s", $time, msg);
		abortRun();
	endtask

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one lfsr step per angle bit
	task automatic nextRandomAngle(output logic [31:0] angle);
		for (int i = 0; i < 32; i++) begin
			angle = {angle[30:0], lfsrState[15]};
			lfsrState = lfsrStep(lfsrState);
		end
	endtask

	// phase is 2*pi*angle/2^32 and magnitude 2^30
	function automatic cordicPkg::cordicResult_t expectedResult(input logic [31:0] angle);
		real                      phase;
		cordicPkg::cordicResult_t r;
		phase = 2.0 * Pi * real'($signed(angle)) / Turn;
		r.cosine = int'(Scale * $cos(phase));
		r.sine = int'(Scale * $sin(phase));
		return r;
	endfunction

	function automatic cordicPkg::wbStatus_t expectedStatus(input int count, input int credits);
		cordicPkg::wbStatus_t s;
		s.count = 16'(count);
		s.credits = 16'(credits);
		return s;
	endfunction

	////////////////////////////////////////
	// wishbone master
	////////////////////////////////////////

	task automatic wbTransfer(input logic we, input logic [`WB_ADR_WIDTH-1:0] adr,
		input logic [31:0] dat, output logic [31:0] rdData);
		@(negedge C);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we = we;
		wbReq.adr = adr;
		wbReq.dat = dat;
		@(negedge C);
		while (!wbRsp.ack) begin
			@(negedge C);
		end
		rdData = wbRsp.dat;
		wbReq.cyc = 1'b0;
		wbReq.stb = 1'b0;
		wbReq.we = 1'b0;
	endtask

	task automatic wbWrite(input logic [`WB_ADR_WIDTH-1:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		wbTransfer(1'b1, adr, dat, unused);
	endtask

	task automatic wbRead(input logic [`WB_ADR_WIDTH-1:0] adr, output logic [31:0] dat);
		wbTransfer(1'b0, adr, '0, dat);
	endtask

	// the sine read after the cosine pops the head
	task automatic readResult(output cordicPkg::cordicResult_t r);
		logic [31:0] c;
		logic [31:0] s;
		wbRead(`ADR_COS, c);
		wbRead(`ADR_SINE, s);
		r.cosine = c;
		r.sine = s;
	endtask

	task automatic readStatus(output cordicPkg::wbStatus_t s);
		logic [31:0] d;
		wbRead(`ADR_STATUS, d);
		s = cordicPkg::wbStatus_t'(d);
	endtask

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////

	task automatic checkResult(input cordicPkg::cordicResult_t got,
		input cordicPkg::cordicResult_t exp, input string what);
		longint dCos;
		longint dSin;
		dCos = longint'(got.cosine) - longint'(exp.cosine);
		dSin = longint'(got.sine) - longint'(exp.sine);
		if (dCos > Tolerance || dCos < -Tolerance || dSin > Tolerance || dSin < -Tolerance) begin
			reportValue($sformatf("%s: cos %0d sin %0d, expected cos %0d sin %0d",
				what, got.cosine, got.sine, exp.cosine, exp.sine));
		end
	endtask

	task automatic checkStatus(input cordicPkg::wbStatus_t got,
		input cordicPkg::wbStatus_t exp, input string what);
		if (got !== exp) begin
			reportValue($sformatf("%s: count %0d credits %0d, expected count %0d credits %0d",
				what, got.count, got.credits, exp.count, exp.credits));
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic testResetState();
		cordicPkg::wbStatus_t s;
		readStatus(s);
		checkStatus(s, expectedStatus(0, `RESULT_DEPTH), "status after reset");
	endtask

	task automatic runAngle(input logic [31:0] angle, input string what);
		cordicPkg::cordicResult_t r;
		wbWrite(`ADR_ANGLE, angle);
		readResult(r);
		checkResult(r, expectedResult(angle), what);
	endtask

	task automatic testQuadrants();
		runAngle(32'h0000_0000, "angle 0");
		runAngle(32'h2000_0000, "angle 45");
		runAngle(32'h4000_0000, "angle 90");
		runAngle(32'h6000_0000, "angle 135");
		runAngle(32'hA000_0000, "angle 225");
		runAngle(32'hE000_0000, "angle 315");
	endtask

	task automatic testRandomBurst();
		logic [31:0]              angles [`RESULT_DEPTH];
		cordicPkg::cordicResult_t r;
		for (int i = 0; i < `RESULT_DEPTH; i++) begin
			nextRandomAngle(angles[i]);
			wbWrite(`ADR_ANGLE, angles[i]);
		end
		for (int i = 0; i < `RESULT_DEPTH; i++) begin
			readResult(r);
			checkResult(r, expectedResult(angles[i]), $sformatf("burst entry %0d", i));
		end
	endtask

	task automatic testWriteBackPressure();
		logic [31:0]              angles [`RESULT_DEPTH];
		logic [31:0]              extra;
		cordicPkg::cordicResult_t r;
		cordicPkg::wbStatus_t     s;
		for (int i = 0; i < `RESULT_DEPTH; i++) begin
			nextRandomAngle(angles[i]);
			wbWrite(`ADR_ANGLE, angles[i]);
		end
		nextRandomAngle(extra);
		// hold one more write with no credit left
		@(negedge C);
		wbReq = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: `ADR_ANGLE, dat: extra};
		for (int i = 0; i < HoldCycles; i++) begin
			@(negedge C);
			if (wbRsp.ack) begin
				$display("an angle write was acked while no credit was free");
				abortRun();
			end
		end
		wbReq = '0;
		readStatus(s);
		checkStatus(s, expectedStatus(`RESULT_DEPTH, 0), "status with full queue");
		readResult(r);
		checkResult(r, expectedResult(angles[0]), "first result after stall");
		wbWrite(`ADR_ANGLE, extra);
		for (int i = 1; i < `RESULT_DEPTH; i++) begin
			readResult(r);
			checkResult(r, expectedResult(angles[i]), $sformatf("stalled entry %0d", i));
		end
		readResult(r);
		checkResult(r, expectedResult(extra), "write completed after a pop");
	endtask

	task automatic testWaitingRead();
		logic [31:0]              angle;
		cordicPkg::cordicResult_t r;
		cordicPkg::wbStatus_t     s;
		nextRandomAngle(angle);
		wbWrite(`ADR_ANGLE, angle);
		// cosine read issued before the result exists
		readResult(r);
		checkResult(r, expectedResult(angle), "waiting read");
		readStatus(s);
		checkStatus(s, expectedStatus(0, `RESULT_DEPTH), "credits restored");
	endtask

	initial begin
		wbReq = '0;
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge C);
		@(negedge C);
		arstN = 1'b1;
		testResetState();
		testQuadrants();
		testRandomBurst();
		testWriteBackPressure();
		testWaitingRead();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

//--- rtl/cordicTop.sv
`timescale 1ns/1ps
`include "cordic_cfg.svh"

module cordicTop (
	input  logic              C,
	input  logic              arstN,
	input  cordicPkg::wbReq_t wbReq,
	output cordicPkg::wbRsp_t wbRsp
);
	logic [31:0]              angleIn;
	logic                     angleValid;
	cordicPkg::cordicVec_t    stageVec [`CORDIC_STAGES + 1];
	cordicPkg::cordicResult_t head;
	logic [15:0]              count;
	logic                     pop;

	wbCordicPort i_wbCordicPort (
		.C          (C),
		.arstN      (arstN),
		.wbReq      (wbReq),
		.wbRsp      (wbRsp),
		.angleIn    (angleIn),
		.angleValid (angleValid),
		.head       (head),
		.count      (count),
		.pop        (pop)
	);

	quadrantFold i_quadrantFold (
		.C          (C),
		.arstN      (arstN),
		.angleIn    (angleIn),
		.angleValid (angleValid),
		.vecOut     (stageVec[0])
	);

	////////////////////////////////////////
	// micro-rotation chain
	////////////////////////////////////////

	for (genvar i = 0; i < `CORDIC_STAGES; i++) begin : gStage
		cordicStage #(
			.StageIdx (i)
		) i_cordicStage (
			.C      (C),
			.arstN  (arstN),
			.vecIn  (stageVec[i]),
			.vecOut (stageVec[i+1])
		);
	end

	resultQueue i_resultQueue (
		.C     (C),
		.arstN (arstN),
		.vecIn (stageVec[`CORDIC_STAGES]),
		.pop   (pop),
		.head  (head),
		.count (count)
	);

endmodule

//--- rtl/resultQueue.sv
`timescale 1ns/1ps
`include "cordic_cfg.svh"

module resultQueue (
	input  logic                     C,
	input  logic                     arstN,
	input  cordicPkg::cordicVec_t    vecIn,
	input  logic                     pop,
	output cordicPkg::cordicResult_t head,
	output logic [15:0]              count
);
	localparam int PtrWidth = (`RESULT_DEPTH > 1) ? $clog2(`RESULT_DEPTH) : 1;
	localparam logic [PtrWidth-1:0] LastIdx = PtrWidth'(`RESULT_DEPTH - 1);
	localparam logic [15:0] Depth = 16'(`RESULT_DEPTH);

	cordicPkg::cordicResult_t mem [`RESULT_DEPTH];
	logic [PtrWidth-1:0]      wrPtr;
	logic [PtrWidth-1:0]      rdPtr;
	logic                     push;

	assign push = vecIn.valid;

	////////////////////////////////////////
	// pointers and fill count
	////////////////////////////////////////

	always_ff @(posedge C or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == LastIdx) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == LastIdx) ? '0 : rdPtr + 1'b1;
			end
			if (push && !pop) begin
				count <= count + 16'd1;
			end else if (pop && !push) begin
				count <= count - 16'd1;
			end
		end
	end

	// x carries cosine, y carries sine
	always_ff @(posedge C) begin
		if (push) begin
			mem[wrPtr].cosine <= vecIn.x;
			mem[wrPtr].sine <= vecIn.y;
		end
	end

	assign head = mem[rdPtr];

	// credit scheme upstream must keep the pipeline from overfilling us
	noOverflow: assert property (@(posedge C) disable iff (!arstN)
		push |-> (count < Depth) || pop);

	noUnderflow: assert property (@(posedge C) disable iff (!arstN)
		pop |-> count != 16'd0);

endmodule

//--- rtl/cordicStage.sv
`timescale 1ns/1ps
`include "cordic_cfg.svh"

module cordicStage #(
	parameter int StageIdx = 0
) (
	input  logic                  C,
	input  logic                  arstN,
	input  cordicPkg::cordicVec_t vecIn,
	output cordicPkg::cordicVec_t vecOut
);
	////////////////////////////////////////
	// atan(2^-i), full turn = 2^32
	////////////////////////////////////////

	localparam logic signed [`CORDIC_WIDTH-1:0] AtanTable [0:30] = '{
		32'h20000000, 32'h12E4051D, 32'h09FB385B, 32'h051111D4,
		32'h028B0D43, 32'h0145D7E1, 32'h00A2F61E, 32'h00517C55,
		32'h0028BE53, 32'h00145F2E, 32'h000A2F98, 32'h000517CC,
		32'h00028BE6, 32'h000145F3, 32'h0000A2F9, 32'h0000517D,
		32'h000028BE, 32'h0000145F, 32'h00000A2F, 32'h00000518,
		32'h0000028C, 32'h00000146, 32'h000000A3, 32'h00000051,
		32'h00000028, 32'h00000014, 32'h0000000A, 32'h00000005,
		32'h00000002, 32'h00000001, 32'h00000000
	};

	localparam logic signed [`CORDIC_WIDTH-1:0] Atan = AtanTable[StageIdx];

	logic                             zNeg;
	logic signed [`CORDIC_WIDTH-1:0] xShift;
	logic signed [`CORDIC_WIDTH-1:0] yShift;
	logic                             validQ;
	logic signed [`CORDIC_WIDTH-1:0] xQ;
	logic signed [`CORDIC_WIDTH-1:0] yQ;
	logic signed [`CORDIC_WIDTH-1:0] zQ;

	// sign of residual angle picks the rotation direction
	assign zNeg = vecIn.z[`CORDIC_WIDTH-1];
	assign xShift = vecIn.x >>> StageIdx;
	assign yShift = vecIn.y >>> StageIdx;

	always_ff @(posedge C or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= vecIn.valid;
		end
	end

	always_ff @(posedge C) begin
		if (zNeg) begin
			// clockwise step
			xQ <= vecIn.x + yShift;
			yQ <= vecIn.y - xShift;
			zQ <= vecIn.z + Atan;
		end else begin
			xQ <= vecIn.x - yShift;
			yQ <= vecIn.y + xShift;
			zQ <= vecIn.z - Atan;
		end
	end

	assign vecOut.valid = validQ;
	assign vecOut.x = xQ;
	assign vecOut.y = yQ;
	assign vecOut.z = zQ;

endmodule

//--- rtl/quadrantFold.sv
`timescale 1ns/1ps
`include "cordic_cfg.svh"

module quadrantFold (
	input  logic                  C,
	input  logic                  arstN,
	input  logic [31:0]           angleIn,
	input  logic                  angleValid,
	output cordicPkg::cordicVec_t vecOut
);
	localparam logic signed [`CORDIC_WIDTH-1:0] GainInv = `CORDIC_GAIN_INV;

	logic                             flip;
	logic                             validQ;
	logic signed [`CORDIC_WIDTH-1:0] xQ;
	logic signed [`CORDIC_WIDTH-1:0] zQ;

	// quadrants 01 and 10 lie beyond +-90 degrees
	assign flip = angleIn[31] ^ angleIn[30];

	always_ff @(posedge C or negedge arstN) begin
		if (!arstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= angleValid;
		end
	end

	// half-turn pre-rotation: negate start x and shift angle by 2^31
	always_ff @(posedge C) begin
		if (flip) begin
			xQ <= -GainInv;
			zQ <= {~angleIn[31], angleIn[30:0]};
		end else begin
			xQ <= GainInv;
			zQ <= angleIn;
		end
	end

	assign vecOut.valid = validQ;
	assign vecOut.x = xQ;
	// start vector always on the x axis
	assign vecOut.y = '0;
	assign vecOut.z = zQ;

endmodule

//--- rtl/wbCordicPort.sv
`timescale 1ns/1ps
`include "cordic_cfg.svh"

module wbCordicPort (
	input  logic                     C,
	input  logic                     arstN,
	input  cordicPkg::wbReq_t        wbReq,
	output cordicPkg::wbRsp_t        wbRsp,
	output logic [31:0]              angleIn,
	output logic                     angleValid,
	input  cordicPkg::cordicResult_t head,
	input  logic [15:0]              count,
	output logic                     pop
);
	localparam logic [15:0] Depth = 16'(`RESULT_DEPTH);

	logic                 ack;
	logic [31:0]          rdData;
	logic [31:0]          rdNext;
	logic [15:0]          credits;
	logic                 req;
	logic                 ready;
	logic                 go;
	logic                 wrAngle;
	logic                 rdSine;
	cordicPkg::wbStatus_t status;

	////////////////////////////////////////
	// request decode
	////////////////////////////////////////

	// no new request while ack is out
	assign req = wbReq.cyc && wbReq.stb && !ack;

	// angle writes need a credit and result reads a queued result
	always_comb begin
		case (wbReq.adr)
			`ADR_ANGLE: ready = !wbReq.we || (credits != 16'd0);
			`ADR_COS, `ADR_SINE: ready = wbReq.we || (count != 16'd0);
			default: ready = 1'b1;
		endcase
	end

	assign go = req && ready;
	assign wrAngle = go && wbReq.we && (wbReq.adr == `ADR_ANGLE);
	// sine read retires the head entry
	assign rdSine = go && !wbReq.we && (wbReq.adr == `ADR_SINE);

	assign status.count = count;
	assign status.credits = credits;

	always_comb begin
		case (wbReq.adr)
			`ADR_COS: rdNext = head.cosine;
			`ADR_SINE: rdNext = head.sine;
			`ADR_STATUS: rdNext = status;
			default: rdNext = '0;
		endcase
	end

	////////////////////////////////////////
	// ack, strobes and credits
	////////////////////////////////////////

	always_ff @(posedge C or negedge arstN) begin
		if (!arstN) begin
			ack <= 1'b0;
			angleValid <= 1'b0;
			pop <= 1'b0;
			credits <= Depth;
		end else begin
			ack <= go;
			angleValid <= wrAngle;
			pop <= rdSine;
			// a pop only lands in an ack cycle, when no write is taken
			if (wrAngle) begin
				credits <= credits - 16'd1;
			end else if (pop) begin
				credits <= credits + 16'd1;
			end
		end
	end

	always_ff @(posedge C) begin
		if (wrAngle) begin
			angleIn <= wbReq.dat;
		end
		if (go && !wbReq.we) begin
			rdData <= rdNext;
		end
	end

	assign wbRsp.ack = ack;
	assign wbRsp.dat = rdData;

	// returned credits never outnumber the queue slots
	creditBound: assert property (@(posedge C) disable iff (!arstN) credits <= Depth);

endmodule

//--- rtl/cordicPkg.sv
`include "cordic_cfg.svh"

package cordicPkg;

	////////////////////////////////////////
	// pipeline payloads
	////////////////////////////////////////

	// one vector moving down the stages
	typedef struct packed {
		logic                             valid;
		logic signed [`CORDIC_WIDTH-1:0] x;
		logic signed [`CORDIC_WIDTH-1:0] y;
		logic signed [`CORDIC_WIDTH-1:0] z;
	} cordicVec_t;

	// finished pair, both Q2.30
	typedef struct packed {
		logic signed [`CORDIC_WIDTH-1:0] cosine;
		logic signed [`CORDIC_WIDTH-1:0] sine;
	} cordicResult_t;

	////////////////////////////////////////
	// wishbone classic
	////////////////////////////////////////

	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [`WB_ADR_WIDTH-1:0] adr;
		logic [`CORDIC_WIDTH-1:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic                     ack;
		logic [`CORDIC_WIDTH-1:0] dat;
	} wbRsp_t;

	// queued count in the upper half
	typedef struct packed {
		logic [15:0] count;
		logic [15:0] credits;
	} wbStatus_t;

endpackage

//--- rtl/cordic_cfg.svh
`ifndef CORDIC_CFG_SVH
`define CORDIC_CFG_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// x, y, z and bus data width
`define CORDIC_WIDTH 32
`define CORDIC_STAGES 28
// 1/K in Q2.30, start magnitude of x
`define CORDIC_GAIN_INV 652032874

// queue entries, also the in-flight limit
`define RESULT_DEPTH 8

////////////////////////////////////////
// register map
////////////////////////////////////////

`define WB_ADR_WIDTH 2
`define ADR_ANGLE 2'd0
`define ADR_COS 2'd1
`define ADR_SINE 2'd2
`define ADR_STATUS 2'd3

`endif
